//--- common/ts_pkg.sv
package ts_pkg;

	// screen X position or scroll offset
	typedef logic [8:0] xcoord_t;

	// bitmap line number
	typedef logic [8:0] bmline_t;

	// graphics page
	typedef logic [7:0] page_t;

	// word address within a bitmap line
	typedef logic [5:0] waddr_t;

	// object width code, width is (code + 1) * 8 pixels
	typedef logic [2:0] xsize_t;

	// renderer palette select
	typedef logic [3:0] pal_t;

	// tile number
	typedef logic [11:0] tnum_t;

	// sprite file address
	typedef logic [7:0] sreg_t;

	// one-hot layer vector
	// order: spr0, tile0, spr1, tile1, spr2
	typedef logic [4:0] layer_t;

	// last descriptor word, descriptors sit at 0, 3, ... 252
	localparam sreg_t SPR_LAST_REG = 8'd254;

	// tsconf bits
	localparam int TCONF_S_EN = 7;
	localparam int TCONF_T1_EN = 6;
	localparam int TCONF_T0_EN = 5;
	localparam int TCONF_T1Z_EN = 3;
	localparam int TCONF_T0Z_EN = 2;

	// layer select bit inside the tilemap read address
	localparam int TMB_LAYER_BIT = 0;

endpackage

//--- hw/sprite_file.sv
`timescale 1ns/1ps

module sprite_file (
	input logic clk,
	input ts_pkg::sreg_t wr_addr,
	input logic [15:0] wr_data,
	input logic we,
	input ts_pkg::sreg_t rd_addr,
	output logic [15:0] rd_data
);

	// three words per sprite, 85 sprites
	logic [15:0] mem [256];

	// host side
	always_ff @(posedge clk)
	begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	// walker side, one cycle latency
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- tiles/ts_tile_walker.sv
`timescale 1ns/1ps

module ts_tile_walker (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [1:0] grant,
	input logic take,
	input ts_pkg::xcoord_t line,
	input logic [5:0] num_tiles,
	input ts_pkg::xcoord_t t0x_offs,
	input ts_pkg::xcoord_t t1x_offs,
	input logic [2:0] t0y_offs,
	input logic [2:0] t1y_offs,
	input ts_pkg::page_t t0gpage,
	input ts_pkg::page_t t1gpage,
	input logic [1:0] t0_palsel,
	input logic [1:0] t1_palsel,
	input logic [1:0] z_en,
	input logic [15:0] tmb_rdata,
	output logic [8:0] tmb_raddr,
	output logic task_valid,
	output logic [1:0] layer_end,
	output ts_pkg::waddr_t t_addr,
	output ts_pkg::bmline_t t_line,
	output ts_pkg::page_t t_page,
	output ts_pkg::xcoord_t t_x,
	output logic t_xf,
	output ts_pkg::pal_t t_pal
);

	logic run;
	logic sel;
	logic [5:0] tx;
	logic [5:0] tpos;
	ts_pkg::xcoord_t x_offs;
	logic [2:0] y_offs;
	ts_pkg::xcoord_t t_row;
	ts_pkg::tnum_t tnum;
	logic t_act;
	logic t_end;
	logic t_next;

	assign run = |grant;
	// layer 1 when its grant is up, layer 0 otherwise
	assign sel = grant[1];

	assign x_offs = sel ? t1x_offs : t0x_offs;
	assign y_offs = sel ? t1y_offs : t0y_offs;
	assign t_row = line + {6'd0, y_offs};

	// tilemap position follows the coarse scroll
	assign tpos = x_offs[8:3] + tx;

	always_comb
	begin
		tmb_raddr = {t_row[4:3], tpos, 1'b0};
		tmb_raddr[ts_pkg::TMB_LAYER_BIT] = sel;
	end

	// entry fields
	assign tnum = tmb_rdata[11:0];
	assign t_act = (tnum != '0) || z_en[sel];

	// columns 0 .. num_tiles-1 are drawn
	assign t_end = run && (tx == num_tiles);
	assign t_next = run && !t_end && (!t_act || take);

	assign task_valid = run && !t_end && t_act;
	assign layer_end = t_end ? grant : 2'b00;

	always_ff @(posedge clk)
	begin
		if (rst)
			tx <= '0;
		else if (start || t_end)
			// next layer starts again from screen column 0
			tx <= '0;
		else if (t_next)
			tx <= tx + 6'd1;
	end

	// task fields
	assign t_line = {tnum[11:6], t_row[2:0] ^ {3{tmb_rdata[15]}}};
	assign t_addr = tnum[5:0];
	assign t_x = {tx, 3'b000} - {6'd0, x_offs[2:0]};
	assign t_xf = tmb_rdata[14];
	assign t_pal = {sel ? t1_palsel : t0_palsel, tmb_rdata[13:12]};
	assign t_page = sel ? t1gpage : t0gpage;

endmodule

//--- sprites/ts_sprite_walker.sv
`timescale 1ns/1ps

module ts_sprite_walker (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [2:0] grant,
	input logic take,
	input ts_pkg::xcoord_t line,
	input ts_pkg::page_t sgpage,
	output ts_pkg::sreg_t sf_raddr,
	input logic [15:0] sf_rdata,
	output logic task_valid,
	output logic [2:0] layer_end,
	output ts_pkg::waddr_t s_addr,
	output ts_pkg::bmline_t s_line,
	output ts_pkg::page_t s_page,
	output ts_pkg::xcoord_t s_x,
	output ts_pkg::xsize_t s_xs,
	output logic s_xf,
	output ts_pkg::pal_t s_pal
);

	logic run;
	// one-hot word ring: word 0, 1, 2
	logic [2:0] sf_valid;
	ts_pkg::sreg_t sreg;

	logic [8:0] s_dy;
	logic [5:0] s_ymax;
	logic [5:0] s_off;
	logic s_visible;
	logic spr_skip;
	logic w0_go;
	logic w1_go;
	logic w2_go;
	logic step;
	logic leap_end;
	logic last_spr;

	// latched descriptor fields
	logic [5:0] off_r;
	logic leap_r;
	ts_pkg::xcoord_t x_r;
	ts_pkg::xsize_t xs_r;
	logic xf_r;

	assign run = |grant;

	// word 0: Y check, wraps so sprites above the line fail too
	assign s_dy = line - sf_rdata[8:0];
	assign s_ymax = {sf_rdata[11:9], 3'b111};
	assign s_visible = s_dy <= {3'b000, s_ymax};
	// mirrored row offset for Y flip
	assign s_off = sf_rdata[15] ? (s_ymax - s_dy[5:0]) : s_dy[5:0];

	assign spr_skip = run && sf_valid[0] && !(s_visible && sf_rdata[13]);
	assign w0_go = run && sf_valid[0] && s_visible && sf_rdata[13];
	assign w1_go = run && sf_valid[1];
	assign w2_go = take && sf_valid[2];
	assign step = w0_go || w1_go || w2_go;

	// a sprite is finished by a skip or by its taken task
	assign leap_end = (spr_skip && sf_rdata[14]) || (w2_go && leap_r);
	assign last_spr = (spr_skip && (sreg == ts_pkg::SPR_LAST_REG - 8'd2)) ||
		(w2_go && (sreg == ts_pkg::SPR_LAST_REG));
	assign layer_end = (leap_end ? grant : 3'b000) | {3{last_spr}};

	// read address runs ahead so rd_data always shows word sreg
	always_comb
	begin
		if (start)
			sf_raddr = '0;
		else if (spr_skip)
			sf_raddr = sreg + 8'd3;
		else if (step)
			sf_raddr = sreg + 8'd1;
		else
			sf_raddr = sreg;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sreg <= '0;
			sf_valid <= 3'b000;
		end
		else
		begin
			sreg <= sf_raddr;
			if (start)
				sf_valid <= 3'b001;
			else if (last_spr)
				// table exhausted, idle until the next line
				sf_valid <= 3'b000;
			else if (step)
				sf_valid <= {sf_valid[1:0], sf_valid[2]};
		end
	end

	always_ff @(posedge clk)
	begin
		if (w0_go)
		begin
			off_r <= s_off;
			leap_r <= sf_rdata[14];
		end
		if (w1_go)
		begin
			x_r <= sf_rdata[8:0];
			xs_r <= sf_rdata[11:9];
			xf_r <= sf_rdata[15];
		end
	end

	// word 2 is still on the RAM output while the task waits
	assign task_valid = sf_valid[2];
	assign s_addr = sf_rdata[5:0];
	assign s_line = {sf_rdata[11:6], 3'b000} + {3'b000, off_r};
	assign s_pal = sf_rdata[15:12];
	assign s_page = sgpage;
	assign s_x = x_r;
	assign s_xs = xs_r;
	assign s_xf = xf_r;

endmodule

//--- hw/ts_layer_sequencer.sv
`timescale 1ns/1ps

module ts_layer_sequencer (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [7:0] tsconf,
	input logic tsr_rdy,
	input logic tile_valid,
	input logic [1:0] tile_end,
	input ts_pkg::waddr_t t_addr,
	input ts_pkg::bmline_t t_line,
	input ts_pkg::page_t t_page,
	input ts_pkg::xcoord_t t_x,
	input logic t_xf,
	input ts_pkg::pal_t t_pal,
	input logic spr_valid,
	input logic [2:0] spr_end,
	input ts_pkg::waddr_t s_addr,
	input ts_pkg::bmline_t s_line,
	input ts_pkg::page_t s_page,
	input ts_pkg::xcoord_t s_x,
	input ts_pkg::xsize_t s_xs,
	input logic s_xf,
	input ts_pkg::pal_t s_pal,
	output logic [1:0] tile_grant,
	output logic [2:0] spr_grant,
	output logic tile_take,
	output logic spr_take,
	output ts_pkg::waddr_t tsr_addr,
	output ts_pkg::bmline_t tsr_line,
	output ts_pkg::page_t tsr_page,
	output ts_pkg::xcoord_t tsr_x,
	output ts_pkg::xsize_t tsr_xs,
	output logic tsr_xf,
	output ts_pkg::pal_t tsr_pal,
	output logic tsr_go,
	output logic ts_done
);

	ts_pkg::layer_t layer;
	ts_pkg::layer_t layer_skip;
	ts_pkg::layer_t layer_dis;
	ts_pkg::layer_t layer_end;
	ts_pkg::layer_t layer_active;
	logic sprites;
	logic tiles;

	// bit order spr0, tile0, spr1, tile1, spr2 from bit 0 up
	assign layer_dis = {!tsconf[ts_pkg::TCONF_S_EN], !tsconf[ts_pkg::TCONF_T1_EN],
		!tsconf[ts_pkg::TCONF_S_EN], !tsconf[ts_pkg::TCONF_T0_EN],
		!tsconf[ts_pkg::TCONF_S_EN]};
	assign layer_end = {spr_end[2], tile_end[1], spr_end[1], tile_end[0], spr_end[0]};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			layer <= '0;
			layer_skip <= '1;
		end
		else if (start)
		begin
			layer <= 5'b00001;
			layer_skip <= layer_dis;
		end
		else
		begin
			layer_skip <= layer_skip | layer_end;
			// step over a skipped layer, one per cycle
			if (|(layer & layer_skip))
				layer <= {layer[3:0], 1'b0};
		end
	end

	assign layer_active = layer & ~layer_skip;
	assign spr_grant = {layer_active[4], layer_active[2], layer_active[0]};
	assign tile_grant = {layer_active[3], layer_active[1]};
	assign sprites = |spr_grant;
	assign tiles = |tile_grant;

	assign tsr_go = tsr_rdy && ((sprites && spr_valid) || (tiles && tile_valid));
	assign spr_take = tsr_go && sprites;
	assign tile_take = tsr_go && tiles;

	// renderer port follows the granted walker
	assign tsr_addr = sprites ? s_addr : t_addr;
	assign tsr_line = sprites ? s_line : t_line;
	assign tsr_page = sprites ? s_page : t_page;
	assign tsr_x = sprites ? s_x : t_x;
	assign tsr_xs = sprites ? s_xs : 3'd0;
	assign tsr_xf = sprites ? s_xf : t_xf;
	assign tsr_pal = sprites ? s_pal : t_pal;

	assign ts_done = &layer_skip;

endmodule

//--- hw/video_ts.sv
`timescale 1ns/1ps

module video_ts (
	input logic clk,
	input logic rst,
	input logic start,
	input ts_pkg::xcoord_t line,
	input logic [7:0] tsconf,
	input ts_pkg::page_t t0gpage,
	input ts_pkg::page_t t1gpage,
	input ts_pkg::page_t sgpage,
	input logic [5:0] num_tiles,
	input ts_pkg::xcoord_t t0x_offs,
	input ts_pkg::xcoord_t t1x_offs,
	input logic [2:0] t0y_offs,
	input logic [2:0] t1y_offs,
	input logic [1:0] t0_palsel,
	input logic [1:0] t1_palsel,
	input ts_pkg::sreg_t sfile_addr_in,
	input logic [15:0] sfile_data_in,
	input logic sfile_we,
	output logic [8:0] tmb_raddr,
	input logic [15:0] tmb_rdata,
	output logic tsr_go,
	output ts_pkg::waddr_t tsr_addr,
	output ts_pkg::bmline_t tsr_line,
	output ts_pkg::page_t tsr_page,
	output ts_pkg::xcoord_t tsr_x,
	output ts_pkg::xsize_t tsr_xs,
	output logic tsr_xf,
	output ts_pkg::pal_t tsr_pal,
	input logic tsr_rdy,
	output logic ts_done
);

	ts_pkg::sreg_t sf_raddr;
	logic [15:0] sf_rdata;
	logic [1:0] z_en;

	logic [1:0] tile_grant;
	logic tile_take;
	logic tile_valid;
	logic [1:0] tile_end;
	ts_pkg::waddr_t t_addr;
	ts_pkg::bmline_t t_line;
	ts_pkg::page_t t_page;
	ts_pkg::xcoord_t t_x;
	logic t_xf;
	ts_pkg::pal_t t_pal;

	logic [2:0] spr_grant;
	logic spr_take;
	logic spr_valid;
	logic [2:0] spr_end;
	ts_pkg::waddr_t s_addr;
	ts_pkg::bmline_t s_line;
	ts_pkg::page_t s_page;
	ts_pkg::xcoord_t s_x;
	ts_pkg::xsize_t s_xs;
	logic s_xf;
	ts_pkg::pal_t s_pal;

	// zero tile enables per tile layer
	assign z_en = {tsconf[ts_pkg::TCONF_T1Z_EN], tsconf[ts_pkg::TCONF_T0Z_EN]};

	sprite_file u_sprite_file (
		.clk(clk), .wr_addr(sfile_addr_in), .wr_data(sfile_data_in), .we(sfile_we),
		.rd_addr(sf_raddr), .rd_data(sf_rdata)
	);

	ts_tile_walker u_tile_walker (
		.clk(clk), .rst(rst), .start(start),
		.grant(tile_grant), .take(tile_take), .line(line), .num_tiles(num_tiles),
		.t0x_offs(t0x_offs), .t1x_offs(t1x_offs),
		.t0y_offs(t0y_offs), .t1y_offs(t1y_offs),
		.t0gpage(t0gpage), .t1gpage(t1gpage),
		.t0_palsel(t0_palsel), .t1_palsel(t1_palsel),
		.z_en(z_en), .tmb_rdata(tmb_rdata), .tmb_raddr(tmb_raddr),
		.task_valid(tile_valid), .layer_end(tile_end),
		.t_addr(t_addr), .t_line(t_line), .t_page(t_page),
		.t_x(t_x), .t_xf(t_xf), .t_pal(t_pal)
	);

	ts_sprite_walker u_sprite_walker (
		.clk(clk), .rst(rst), .start(start),
		.grant(spr_grant), .take(spr_take), .line(line), .sgpage(sgpage),
		.sf_raddr(sf_raddr), .sf_rdata(sf_rdata),
		.task_valid(spr_valid), .layer_end(spr_end),
		.s_addr(s_addr), .s_line(s_line), .s_page(s_page),
		.s_x(s_x), .s_xs(s_xs), .s_xf(s_xf), .s_pal(s_pal)
	);

	ts_layer_sequencer u_layer_sequencer (
		.clk(clk), .rst(rst), .start(start), .tsconf(tsconf), .tsr_rdy(tsr_rdy),
		.tile_valid(tile_valid), .tile_end(tile_end),
		.t_addr(t_addr), .t_line(t_line), .t_page(t_page),
		.t_x(t_x), .t_xf(t_xf), .t_pal(t_pal),
		.spr_valid(spr_valid), .spr_end(spr_end),
		.s_addr(s_addr), .s_line(s_line), .s_page(s_page),
		.s_x(s_x), .s_xs(s_xs), .s_xf(s_xf), .s_pal(s_pal),
		.tile_grant(tile_grant), .spr_grant(spr_grant),
		.tile_take(tile_take), .spr_take(spr_take),
		.tsr_addr(tsr_addr), .tsr_line(tsr_line), .tsr_page(tsr_page),
		.tsr_x(tsr_x), .tsr_xs(tsr_xs), .tsr_xf(tsr_xf), .tsr_pal(tsr_pal),
		.tsr_go(tsr_go), .ts_done(ts_done)
	);

endmodule

//--- sim/video_ts_properties.sv
`timescale 1ns/1ps

module video_ts_properties (
	input logic clk,
	input logic rst,
	input logic tsr_go,
	input logic tsr_rdy,
	input ts_pkg::waddr_t tsr_addr,
	input ts_pkg::bmline_t tsr_line,
	input ts_pkg::page_t tsr_page,
	input ts_pkg::xcoord_t tsr_x,
	input ts_pkg::xsize_t tsr_xs,
	input logic tsr_xf,
	input ts_pkg::pal_t tsr_pal,
	input logic ts_done
);

	// count of assertion failures so far
	int fails = 0;

	// a task handed over needs ready and fully known fields
	go_task_valid: assert property (@(posedge clk) disable iff (rst)
		tsr_go |-> tsr_rdy &&
		!$isunknown({tsr_addr, tsr_line, tsr_page, tsr_x, tsr_xs, tsr_xf, tsr_pal}))
	else
	begin
		fails++;
		$error("tsr_go raised without tsr_rdy or with unknown task fields");
	end

	no_go_when_done: assert property (@(posedge clk) disable iff (rst) tsr_go |-> !ts_done)
	else
	begin
		fails++;
		$error("tsr_go raised while ts_done is high");
	end

	// unit is idle shortly after reset
	done_after_reset: assert property (@(posedge clk) $fell(rst) |-> ##[0:2] ts_done)
	else
	begin
		fails++;
		$error("ts_done not high after reset");
	end

endmodule

bind video_ts video_ts_properties u_video_ts_props (
	.clk(clk), .rst(rst), .tsr_go(tsr_go), .tsr_rdy(tsr_rdy),
	.tsr_addr(tsr_addr), .tsr_line(tsr_line), .tsr_page(tsr_page), .tsr_x(tsr_x),
	.tsr_xs(tsr_xs), .tsr_xf(tsr_xf), .tsr_pal(tsr_pal), .ts_done(ts_done)
);

//--- sim/tb_video_ts.sv
`timescale 1ns/1ps

module tb_video_ts;

	localparam int NUM_TESTS = 6;
	localparam int LINES_PER_TEST = 4;
	localparam int CYCLE_LIMIT = 600 * NUM_TESTS * LINES_PER_TEST;
	localparam int NUM_SPR = 85;

	logic clk;
	logic rst;
	logic start;
	ts_pkg::xcoord_t line;
	logic [7:0] tsconf;
	ts_pkg::page_t t0gpage;
	ts_pkg::page_t t1gpage;
	ts_pkg::page_t sgpage;
	logic [5:0] num_tiles;
	ts_pkg::xcoord_t t0x_offs;
	ts_pkg::xcoord_t t1x_offs;
	logic [2:0] t0y_offs;
	logic [2:0] t1y_offs;
	logic [1:0] t0_palsel;
	logic [1:0] t1_palsel;
	ts_pkg::sreg_t sfile_addr_in;
	logic [15:0] sfile_data_in;
	logic sfile_we;
	logic [8:0] tmb_raddr;
	logic [15:0] tmb_rdata;
	logic tsr_go;
	ts_pkg::waddr_t tsr_addr;
	ts_pkg::bmline_t tsr_line;
	ts_pkg::page_t tsr_page;
	ts_pkg::xcoord_t tsr_x;
	ts_pkg::xsize_t tsr_xs;
	logic tsr_xf;
	ts_pkg::pal_t tsr_pal;
	logic tsr_rdy;
	logic ts_done;

	// outside models
	logic [15:0] tilemap [512];
	logic [15:0] spr_mem [256];

	integer seed;
	int rdy_pct;
	int zero_den;
	bit in_line;
	int line_cycles;
	int checks;
	int errors;
	int tests_failed;
	int spr_idx;
	bit spr_exhausted;

	// one task per entry: addr, line, page, x, xs, xf, pal
	logic [39:0] exp_q [$];
	logic [39:0] got_q [$];

	video_ts u_video_ts (
		.clk(clk), .rst(rst), .start(start), .line(line), .tsconf(tsconf),
		.t0gpage(t0gpage), .t1gpage(t1gpage), .sgpage(sgpage), .num_tiles(num_tiles),
		.t0x_offs(t0x_offs), .t1x_offs(t1x_offs), .t0y_offs(t0y_offs), .t1y_offs(t1y_offs),
		.t0_palsel(t0_palsel), .t1_palsel(t1_palsel),
		.sfile_addr_in(sfile_addr_in), .sfile_data_in(sfile_data_in), .sfile_we(sfile_we),
		.tmb_raddr(tmb_raddr), .tmb_rdata(tmb_rdata),
		.tsr_go(tsr_go), .tsr_addr(tsr_addr), .tsr_line(tsr_line), .tsr_page(tsr_page),
		.tsr_x(tsr_x), .tsr_xs(tsr_xs), .tsr_xf(tsr_xf), .tsr_pal(tsr_pal),
		.tsr_rdy(tsr_rdy), .ts_done(ts_done)
	);

	// tilemap buffer answers in the same cycle
	assign tmb_rdata = tilemap[tmb_raddr];

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	function automatic logic [39:0] pack_task(ts_pkg::waddr_t addr, ts_pkg::bmline_t bl,
		ts_pkg::page_t page, ts_pkg::xcoord_t x, ts_pkg::xsize_t xs, logic xf, ts_pkg::pal_t pal);
		return {addr, bl, page, x, xs, xf, pal};
	endfunction

	function automatic int rand_below(int n);
		int r;
		r = $random(seed) & 32'h7fffffff;
		return r % n;
	endfunction

	// renderer takes whatever is offered in a ready cycle
	always @(posedge clk)
	begin
		if (tsr_go)
			got_q.push_back(pack_task(tsr_addr, tsr_line, tsr_page, tsr_x, tsr_xs, tsr_xf,
				tsr_pal));
	end

	// watchdog over the cycles spent inside lines
	initial
	begin
		line_cycles = 0;
		while (line_cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			if (in_line)
				line_cycles++;
		end
		$display("timeout: ts_done not reached within %0d line cycles", CYCLE_LIMIT);
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic next_cycle();
		@(negedge clk);
		tsr_rdy = rand_below(100) < rdy_pct;
	endtask

	task automatic compare_xcoord(string name, ts_pkg::xcoord_t exp, ts_pkg::xcoord_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("MISMATCH time %0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic compare_bmline(string name, ts_pkg::bmline_t exp, ts_pkg::bmline_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("MISMATCH time %0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic compare_page(string name, ts_pkg::page_t exp, ts_pkg::page_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("MISMATCH time %0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic compare_waddr(string name, ts_pkg::waddr_t exp, ts_pkg::waddr_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("MISMATCH time %0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic compare_xsize(string name, ts_pkg::xsize_t exp, ts_pkg::xsize_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("MISMATCH time %0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic compare_pal(string name, ts_pkg::pal_t exp, ts_pkg::pal_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("MISMATCH time %0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic compare_flag(string name, logic exp, logic act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("MISMATCH time %0t %s expected %0b actual %0b", $time, name, exp, act);
		end
	endtask

	task automatic compare_count(string name, int exp, int act);
		checks++;
		if (exp != act)
		begin
			errors++;
			$display("MISMATCH time %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	// one tile layer row, columns 0 .. num_tiles-1
	task automatic model_tiles(int layer);
		ts_pkg::xcoord_t xo;
		ts_pkg::xcoord_t row;
		logic [5:0] pos;
		logic [8:0] a;
		logic [15:0] e;
		logic [2:0] fine;
		int c;
		xo = layer ? t1x_offs : t0x_offs;
		row = line + (layer ? t1y_offs : t0y_offs);
		for (c = 0; c < num_tiles; c++)
		begin
			pos = xo[8:3] + c;
			a = {row[4:3], pos, 1'b0};
			a[ts_pkg::TMB_LAYER_BIT] = layer;
			e = tilemap[a];
			if (e[11:0] != 0 || tsconf[layer ? ts_pkg::TCONF_T1Z_EN : ts_pkg::TCONF_T0Z_EN])
			begin
				fine = e[15] ? ~row[2:0] : row[2:0];
				exp_q.push_back(pack_task(e[5:0], {e[11:6], fine},
					layer ? t1gpage : t0gpage, ts_pkg::xcoord_t'(c * 8 - xo[2:0]), 3'd0,
					e[14], {layer ? t1_palsel : t0_palsel, e[13:12]}));
			end
		end
	endtask

	// one sprite layer, up to a leap bit or the end of the table
	task automatic model_sprites();
		logic [15:0] d0;
		logic [15:0] d1;
		logic [15:0] d2;
		int dy;
		int ymax;
		int off;
		bit leap;
		bit last;
		if (!tsconf[ts_pkg::TCONF_S_EN] || spr_exhausted)
			return;
		do
		begin
			d0 = spr_mem[spr_idx * 3];
			d1 = spr_mem[spr_idx * 3 + 1];
			d2 = spr_mem[spr_idx * 3 + 2];
			dy = (int'(line) - int'(d0[8:0]) + 512) % 512;
			ymax = d0[11:9] * 8 + 7;
			if (d0[13] && dy <= ymax)
			begin
				off = d0[15] ? ymax - dy : dy;
				exp_q.push_back(pack_task(d2[5:0], ts_pkg::bmline_t'(d2[11:6] * 8 + off),
					sgpage, d1[8:0], d1[11:9], d1[15], d2[15:12]));
			end
			leap = d0[14];
			last = (spr_idx == NUM_SPR - 1);
			spr_idx++;
			if (last)
				spr_exhausted = 1'b1;
		end
		while (!(leap || last));
	endtask

	task automatic build_expected();
		exp_q.delete();
		spr_idx = 0;
		spr_exhausted = 1'b0;
		model_sprites();
		if (tsconf[ts_pkg::TCONF_T0_EN])
			model_tiles(0);
		model_sprites();
		if (tsconf[ts_pkg::TCONF_T1_EN])
			model_tiles(1);
		model_sprites();
	endtask

	task automatic fill_tilemap();
		logic [15:0] e;
		int a;
		for (a = 0; a < 512; a++)
		begin
			e = $random(seed);
			if (rand_below(zero_den) == 0)
				e[11:0] = '0;
			tilemap[a] = e;
		end
	endtask

	task automatic fill_sprite_file();
		logic [15:0] w;
		logic [2:0] ys;
		ts_pkg::xcoord_t y;
		logic yflip;
		logic leap;
		logic act;
		int a;
		for (a = 0; a < 256; a++)
		begin
			w = $random(seed);
			if (a % 3 == 0)
			begin
				// Y mostly near the line so about half the sprites are visible
				ys = rand_below(8);
				if (rand_below(4) == 0)
					y = $random(seed);
				else
					y = line - ts_pkg::xcoord_t'(rand_below(ys * 8 + 16));
				yflip = rand_below(2);
				leap = rand_below(8) == 0;
				act = rand_below(8) != 0;
				w = {yflip, leap, act, 1'b0, ys, y};
			end
			next_cycle();
			sfile_we = 1'b1;
			sfile_addr_in = a;
			sfile_data_in = w;
			spr_mem[a] = w;
		end
		next_cycle();
		sfile_we = 1'b0;
	endtask

	task automatic set_scene(int test, int k);
		rdy_pct = (test == 6) ? 40 : 85;
		zero_den = (test == 2) ? 2 : 4;
		line = $random(seed);
		tsconf = $random(seed);
		t0gpage = $random(seed);
		t1gpage = $random(seed);
		sgpage = $random(seed);
		num_tiles = rand_below(64);
		t0x_offs = $random(seed);
		t1x_offs = $random(seed);
		t0y_offs = $random(seed);
		t1y_offs = $random(seed);
		t0_palsel = $random(seed);
		t1_palsel = $random(seed);
		tsconf[ts_pkg::TCONF_S_EN] = (test != 1 && test != 2);
		tsconf[ts_pkg::TCONF_T0_EN] = (test != 3);
		tsconf[ts_pkg::TCONF_T1_EN] = (test != 3);
		if (test == 1)
		begin
			tsconf[ts_pkg::TCONF_T0Z_EN] = 1'b0;
			tsconf[ts_pkg::TCONF_T1Z_EN] = 1'b0;
		end
		if (test == 2)
		begin
			tsconf[ts_pkg::TCONF_T0Z_EN] = k[0];
			tsconf[ts_pkg::TCONF_T1Z_EN] = k[1];
		end
		// one enable cleared per line, last line random
		if (test == 5 && k == 0)
			tsconf[ts_pkg::TCONF_S_EN] = 1'b0;
		if (test == 5 && k == 1)
			tsconf[ts_pkg::TCONF_T0_EN] = 1'b0;
		if (test == 5 && k == 2)
			tsconf[ts_pkg::TCONF_T1_EN] = 1'b0;
		if (test == 5 && k == 3)
			tsconf[7:5] = $random(seed);
	endtask

	task automatic run_line();
		got_q.delete();
		next_cycle();
		start = 1'b1;
		in_line = 1'b1;
		next_cycle();
		start = 1'b0;
		while (!ts_done)
			next_cycle();
		in_line = 1'b0;
	endtask

	task automatic check_line();
		int i;
		logic [39:0] e;
		logic [39:0] g;
		compare_count("task count", exp_q.size(), got_q.size());
		for (i = 0; i < exp_q.size() && i < got_q.size(); i++)
		begin
			e = exp_q[i];
			g = got_q[i];
			compare_waddr($sformatf("tsr_addr #%0d", i), e[39:34], g[39:34]);
			compare_bmline($sformatf("tsr_line #%0d", i), e[33:25], g[33:25]);
			compare_page($sformatf("tsr_page #%0d", i), e[24:17], g[24:17]);
			compare_xcoord($sformatf("tsr_x #%0d", i), e[16:8], g[16:8]);
			compare_xsize($sformatf("tsr_xs #%0d", i), e[7:5], g[7:5]);
			compare_flag($sformatf("tsr_xf #%0d", i), e[4], g[4]);
			compare_pal($sformatf("tsr_pal #%0d", i), e[3:0], g[3:0]);
		end
	endtask

	task automatic run_test(int test, string name);
		int k;
		int errors_before;
		int tasks;
		errors_before = errors;
		tasks = 0;
		for (k = 0; k < LINES_PER_TEST; k++)
		begin
			set_scene(test, k);
			fill_tilemap();
			fill_sprite_file();
			build_expected();
			run_line();
			check_line();
			tasks += exp_q.size();
		end
		if (errors != errors_before)
			tests_failed++;
		$display("test %0d %s: %0d lines, %0d tasks, %0d errors, %s", test, name,
			LINES_PER_TEST, tasks, errors - errors_before,
			(errors == errors_before) ? "ok" : "failed");
	endtask

	initial
	begin
		seed = 32'h9eb;
		checks = 0;
		errors = 0;
		tests_failed = 0;
		in_line = 1'b0;
		rdy_pct = 100;
		zero_den = 4;
		rst = 1'b1;
		start = 1'b0;
		line = '0;
		tsconf = '0;
		t0gpage = '0;
		t1gpage = '0;
		sgpage = '0;
		num_tiles = '0;
		t0x_offs = '0;
		t1x_offs = '0;
		t0y_offs = '0;
		t1y_offs = '0;
		t0_palsel = '0;
		t1_palsel = '0;
		sfile_addr_in = '0;
		sfile_data_in = '0;
		sfile_we = 1'b0;
		tsr_rdy = 1'b0;
		fill_tilemap();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		run_test(1, "tile tasks");
		run_test(2, "zero tiles");
		run_test(3, "sprite geometry");
		run_test(4, "layer order");
		run_test(5, "layer enables");
		run_test(6, "back-pressure");

		errors += u_video_ts.u_video_ts_props.fails;
		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			NUM_TESTS, tests_failed, checks, errors, u_video_ts.u_video_ts_props.fails);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- compile.f
common/ts_pkg.sv
hw/sprite_file.sv
tiles/ts_tile_walker.sv
sprites/ts_sprite_walker.sv
hw/ts_layer_sequencer.sv
hw/video_ts.sv
sim/video_ts_properties.sv
sim/tb_video_ts.sv

//--- Bender.yml
package:
  name: video_ts

sources:
  - common/ts_pkg.sv
  - hw/sprite_file.sv
  - tiles/ts_tile_walker.sv
  - sprites/ts_sprite_walker.sv
  - hw/ts_layer_sequencer.sv
  - hw/video_ts.sv
  - target: simulation
    files:
      - sim/video_ts_properties.sv
      - sim/tb_video_ts.sv
